//--- sim.f
hw/rvIsaPkg.sv
hw/pipeCtrlPkg.sv
hw/fetchStage.sv
hw/regFile.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/riscvCore.sv
bench/clockGen.sv
bench/coreTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module coreTb -o coreSim \
    || { echo "build failed"; exit 1; }

out=$(./obj_dir/coreSim)
echo "$out"

echo "$out" | grep -qx "Test completed successfully" && exit 0 || exit 1

//--- bench/coreTb.sv
module coreTb;

    typedef enum int {
        kAdd, kSub, kAnd, kOr, kXor, kSlt, kSll, kSrl, kSra,
        kAddi, kAndi, kOri, kXori, kSlti, kSlli, kSrli, kSrai,
        kLw, kSw
    } instrKind_e;

    logic                clk;
    logic                rst_n;
    logic                icacheRen;
    rvIsaPkg::wordAddr_t icacheAddr;
    rvIsaPkg::word_t     icacheRdata;
    logic                icacheStall;
    logic                dcacheRen;
    logic                dcacheWen;
    rvIsaPkg::wordAddr_t dcacheAddr;
    rvIsaPkg::word_t     dcacheWdata;
    rvIsaPkg::word_t     dcacheRdata;
    logic                dcacheStall;

    rvIsaPkg::word_t imem [256];
    rvIsaPkg::word_t dmem [64];
    instrKind_e      progKind [$];
    int              progRd [$];
    int              progRs1 [$];
    int              progRs2 [$];
    int              progImm [$];
    rvIsaPkg::word_t expAddr [$];
    rvIsaPkg::word_t expData [$];
    int              storeOff;
    int              firstMem;
    int              storeCount;
    int              errors;
    int              checks;
    int              testsRun;
    logic            stallMode;
    integer          seed;

    clockGen #(.period(40)) uClock (.clk(clk));

    riscvCore #(.resetPc(pipeCtrlPkg::defaultResetPc)) DUT (
        .clk(clk), .rst_n(rst_n),
        .icacheRen(icacheRen), .icacheAddr(icacheAddr),
        .icacheRdata(icacheRdata), .icacheStall(icacheStall),
        .dcacheRen(dcacheRen), .dcacheWen(dcacheWen), .dcacheAddr(dcacheAddr),
        .dcacheWdata(dcacheWdata), .dcacheRdata(dcacheRdata), .dcacheStall(dcacheStall)
    );

    // past the program only nops are fetched
    assign icacheRdata = (icacheAddr < 30'd256) ? imem[icacheAddr[7:0]] : rvIsaPkg::nopWord;
    assign dcacheRdata = dmem[dcacheAddr[5:0]];

    function automatic rvIsaPkg::word_t fillWord(int idx);
        return 32'hc0de_0000 ^ (idx * 32'h0103_0507) ^ ~idx;
    endfunction

    function automatic rvIsaPkg::word_t encR(logic [6:0] f7, logic [2:0] f3,
                                             int rd, int rs1, int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rvIsaPkg::opOp};
    endfunction

    function automatic rvIsaPkg::word_t encI(logic [6:0] opc, logic [2:0] f3,
                                             int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic rvIsaPkg::word_t encS(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], rvIsaPkg::f3Word, imm[4:0], rvIsaPkg::opStore};
    endfunction

    function automatic rvIsaPkg::word_t encode(instrKind_e k, int rd, int rs1, int rs2, int imm);
        case (k)
            kAdd:  return encR(rvIsaPkg::f7Base, rvIsaPkg::f3AddSub, rd, rs1, rs2);
            kSub:  return encR(rvIsaPkg::f7Alt, rvIsaPkg::f3AddSub, rd, rs1, rs2);
            kAnd:  return encR(rvIsaPkg::f7Base, rvIsaPkg::f3And, rd, rs1, rs2);
            kOr:   return encR(rvIsaPkg::f7Base, rvIsaPkg::f3Or, rd, rs1, rs2);
            kXor:  return encR(rvIsaPkg::f7Base, rvIsaPkg::f3Xor, rd, rs1, rs2);
            kSlt:  return encR(rvIsaPkg::f7Base, rvIsaPkg::f3Slt, rd, rs1, rs2);
            kSll:  return encR(rvIsaPkg::f7Base, rvIsaPkg::f3Sll, rd, rs1, rs2);
            kSrl:  return encR(rvIsaPkg::f7Base, rvIsaPkg::f3SrlSra, rd, rs1, rs2);
            kSra:  return encR(rvIsaPkg::f7Alt, rvIsaPkg::f3SrlSra, rd, rs1, rs2);
            kAddi: return encI(rvIsaPkg::opOpImm, rvIsaPkg::f3AddSub, rd, rs1, imm);
            kAndi: return encI(rvIsaPkg::opOpImm, rvIsaPkg::f3And, rd, rs1, imm);
            kOri:  return encI(rvIsaPkg::opOpImm, rvIsaPkg::f3Or, rd, rs1, imm);
            kXori: return encI(rvIsaPkg::opOpImm, rvIsaPkg::f3Xor, rd, rs1, imm);
            kSlti: return encI(rvIsaPkg::opOpImm, rvIsaPkg::f3Slt, rd, rs1, imm);
            kSlli: return encI(rvIsaPkg::opOpImm, rvIsaPkg::f3Sll, rd, rs1, imm & 31);
            kSrli: return encI(rvIsaPkg::opOpImm, rvIsaPkg::f3SrlSra, rd, rs1, imm & 31);
            kSrai: return encI(rvIsaPkg::opOpImm, rvIsaPkg::f3SrlSra, rd, rs1,
                               32'h400 | (imm & 31)); // funct7 0100000
            kLw:   return encI(rvIsaPkg::opLoad, rvIsaPkg::f3Word, rd, rs1, imm);
            default: return encS(rs2, rs1, imm);
        endcase
    endfunction

    task automatic addInstr(instrKind_e k, int rd, int rs1, int rs2, int imm);
        if (firstMem < 0 && (k == kLw || k == kSw)) begin
            firstMem = progKind.size();
        end
        progKind.push_back(k);
        progRd.push_back(rd);
        progRs1.push_back(rs1);
        progRs2.push_back(rs2);
        progImm.push_back(imm);
    endtask

    task automatic storeReg(int rs);
        addInstr(kSw, 0, 0, rs, storeOff);
        storeOff += 4;
    endtask

    task automatic buildProgram();
        instrKind_e rOps [9];
        instrKind_e iOps [9];
        int         iImm [9];
        int         iSrc [9];
        rOps = '{kAdd, kSub, kAnd, kOr, kXor, kSlt, kSll, kSrl, kSra};
        iOps = '{kAddi, kAndi, kOri, kXori, kSlti, kSlti, kSlli, kSrli, kSrai};
        iImm = '{-100, 'h0f0, 'h555, -1, -3, 0, 7, 4, 4};
        iSrc = '{2, 1, 2, 1, 2, 6, 1, 6, 6};
        storeOff = 'h80;
        firstMem = -1;
        addInstr(kAddi, 1, 0, 0, 'h123);
        addInstr(kAddi, 2, 0, 0, -7);
        addInstr(kAddi, 5, 0, 0, -1);
        addInstr(kSlli, 6, 5, 0, 31); // most negative word
        addInstr(kSub, 7, 6, 1, 0);   // wraps to positive
        storeReg(7);
        foreach (rOps[i]) begin
            addInstr(rOps[i], 10, 2, 1, 0);
            storeReg(10);
        end
        addInstr(kSlt, 10, 1, 2, 0);
        storeReg(10);
        addInstr(kSll, 10, 1, 2, 0);
        storeReg(10);
        foreach (iOps[i]) begin
            addInstr(iOps[i], 10, iSrc[i], 0, iImm[i]);
            storeReg(10);
        end
        // dependent chains
        addInstr(kAdd, 11, 1, 1, 0);
        addInstr(kAdd, 11, 11, 1, 0);
        addInstr(kAdd, 12, 11, 11, 0);
        addInstr(kSub, 13, 12, 11, 0);
        storeReg(13);
        addInstr(kAddi, 14, 0, 0, 1);
        addInstr(kAddi, 14, 0, 0, 2);
        addInstr(kAdd, 15, 14, 14, 0); // newer value of x14 wins
        storeReg(15);
        // load-use
        addInstr(kLw, 3, 0, 0, 'h10);
        addInstr(kAdd, 4, 3, 1, 0);
        storeReg(4);
        addInstr(kLw, 16, 0, 0, 'h14);
        storeReg(16);
        addInstr(kLw, 17, 0, 0, 'h18);
        addInstr(kAddi, 18, 17, 0, 5);
        storeReg(18);
        addInstr(kLw, 20, 0, 0, 'h80);
        storeReg(20);
        // x0 stays zero
        addInstr(kAddi, 0, 0, 0, 55);
        addInstr(kAdd, 0, 1, 1, 0);
        storeReg(0);
        addInstr(kAddi, 19, 0, 0, 3);
        storeReg(19);
        // read in decode while writeback writes
        addInstr(kAddi, 21, 0, 0, 77);
        addInstr(kAddi, 22, 0, 0, 1);
        addInstr(kAddi, 23, 0, 0, 2);
        addInstr(kAdd, 24, 21, 0, 0);
        storeReg(24);
        foreach (progKind[i]) begin
            imem[i] = encode(progKind[i], progRd[i], progRs1[i], progRs2[i], progImm[i]);
        end
    endtask

    // sequential model of the program, gives the ordered store list
    function automatic int runReference();
        rvIsaPkg::word_t r [32];
        rvIsaPkg::word_t m [64];
        rvIsaPkg::word_t a;
        rvIsaPkg::word_t b;
        rvIsaPkg::word_t iw;
        rvIsaPkg::word_t res;
        for (int i = 0; i < 32; i++) begin
            r[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            m[i] = fillWord(i);
        end
        expAddr.delete();
        expData.delete();
        foreach (progKind[n]) begin
            a   = r[progRs1[n]];
            b   = r[progRs2[n]];
            iw  = progImm[n];
            res = '0;
            case (progKind[n])
                kAdd:  res = a + b;
                kSub:  res = a - b;
                kAnd:  res = a & b;
                kOr:   res = a | b;
                kXor:  res = a ^ b;
                kSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                kSll:  res = a << b[4:0];
                kSrl:  res = a >> b[4:0];
                kSra:  res = $signed(a) >>> b[4:0];
                kAddi: res = a + iw;
                kAndi: res = a & iw;
                kOri:  res = a | iw;
                kXori: res = a ^ iw;
                kSlti: res = ($signed(a) < $signed(iw)) ? 32'd1 : 32'd0;
                kSlli: res = a << iw[4:0];
                kSrli: res = a >> iw[4:0];
                kSrai: res = $signed(a) >>> iw[4:0];
                kLw:   res = m[((a + iw) >> 2) & 63];
                default: begin
                    expAddr.push_back((a + iw) >> 2);
                    expData.push_back(b);
                    m[((a + iw) >> 2) & 63] = b;
                end
            endcase
            if (progKind[n] != kSw && progRd[n] != 0) begin
                r[progRd[n]] = res;
            end
        end
        return expAddr.size();
    endfunction

    task automatic checkValue(string name, rvIsaPkg::word_t got, rvIsaPkg::word_t exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // store compare and data memory update
    always @(negedge clk) begin
        if (rst_n && dcacheWen && !dcacheStall) begin
            if (storeCount < expAddr.size()) begin
                checkValue("dcacheAddr", {2'b00, dcacheAddr}, expAddr[storeCount]);
                checkValue("dcacheWdata", dcacheWdata, expData[storeCount]);
            end else begin
                $display("store %0d to word %h was not expected", storeCount, dcacheAddr);
                errors++;
            end
            storeCount++;
            dmem[dcacheAddr[5:0]] = dcacheWdata;
        end
    end

    always @(posedge clk) begin
        #5;
        if (stallMode) begin
            icacheStall = ($random(seed) & 3) == 0;
            dcacheStall = ($random(seed) & 3) == 0;
        end else begin
            icacheStall = 1'b0;
            dcacheStall = 1'b0;
        end
    end

    task automatic resetCore();
        @(posedge clk);
        #5;
        rst_n = 1'b0;
        storeCount = 0;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fillWord(i);
        end
        repeat (10) @(posedge clk);
        #5;
        rst_n = 1'b1;
    endtask

    task automatic runTest(string name, logic withStalls);
        int errBefore;
        int waited;
        errBefore = errors;
        resetCore();
        stallMode = withStalls;
        // strobes idle until the first load or store reaches MEM
        repeat (firstMem + 3) begin
            @(negedge clk);
            checkValue("icacheRen", {31'b0, icacheRen}, 32'd1);
            checkValue("dcacheRen", {31'b0, dcacheRen}, 32'd0);
            checkValue("dcacheWen", {31'b0, dcacheWen}, 32'd0);
        end
        waited = 0;
        while (storeCount < expAddr.size() && waited < 2000) begin
            @(posedge clk);
            waited++;
        end
        if (storeCount < expAddr.size()) begin
            $display("timed out in %s: only %0d of %0d stores seen",
                     name, storeCount, expAddr.size());
            errors++;
        end
        repeat (10) @(posedge clk); // catch stray stores
        stallMode = 1'b0;
        testsRun++;
        $display("test %s finished: %0d stores, %0d errors", name, storeCount,
                 errors - errBefore);
    endtask

    initial begin
        rst_n       = 1'b0;
        icacheStall = 1'b0;
        dcacheStall = 1'b0;
        stallMode   = 1'b0;
        seed        = 32'h5ef8;
        errors      = 0;
        checks      = 0;
        testsRun    = 0;
        storeCount  = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = rvIsaPkg::nopWord;
        end
        buildProgram();
        void'(runReference());
        runTest("noStalls", 1'b0);
        runTest("randomStalls", 1'b1);
        $display("tests %0d, checks %0d, errors %0d", testsRun, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- bench/clockGen.sv
module clockGen #(
    parameter int period = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(period / 2);
        clk = ~clk;
    end

endmodule

//--- hw/riscvCore.sv
module riscvCore #(
    parameter rvIsaPkg::word_t resetPc = pipeCtrlPkg::defaultResetPc
) (
    input  logic                clk,
    input  logic                rst_n,
    output logic                icacheRen,
    output rvIsaPkg::wordAddr_t icacheAddr,
    input  rvIsaPkg::word_t     icacheRdata,
    input  logic                icacheStall,
    output logic                dcacheRen,
    output logic                dcacheWen,
    output rvIsaPkg::wordAddr_t dcacheAddr,
    output rvIsaPkg::word_t     dcacheWdata,
    input  rvIsaPkg::word_t     dcacheRdata,
    input  logic                dcacheStall
);

    rvIsaPkg::word_t     pc;
    rvIsaPkg::word_t     instr;
    logic                hold;
    rvIsaPkg::regIdx_t   rs1;
    rvIsaPkg::regIdx_t   rs2;
    rvIsaPkg::word_t     rs1Data;
    rvIsaPkg::word_t     rs2Data;
    rvIsaPkg::word_t     rs1Val;
    rvIsaPkg::word_t     rs2Val;
    rvIsaPkg::word_t     imm;
    rvIsaPkg::regIdx_t   exRs1;
    rvIsaPkg::regIdx_t   exRs2;
    rvIsaPkg::regIdx_t   rd;
    pipeCtrlPkg::aluOp_e aluOp;
    logic                aluSrcImm;
    logic                memRead;
    logic                memWrite;
    logic                regWrite;
    rvIsaPkg::regIdx_t   exRd;
    logic                exMemRead;
    logic                wbEn;
    rvIsaPkg::regIdx_t   wbRd;
    rvIsaPkg::word_t     wbData;

    assign icacheRen = 1'b1; // fetch every cycle

    fetchStage #(.resetPc(resetPc)) uFetch (
        .clk(clk), .rst_n(rst_n),
        .icacheAddr(icacheAddr), .icacheRdata(icacheRdata), .icacheStall(icacheStall),
        .dcacheStall(dcacheStall), .hold(hold),
        .pc(pc), .instr(instr)
    );

    decodeStage uDecode (
        .clk(clk), .rst_n(rst_n), .dcacheStall(dcacheStall),
        .pc(pc), .instr(instr),
        .rs1(rs1), .rs2(rs2), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .exRd(exRd), .exMemRead(exMemRead), .hold(hold),
        .rs1Val(rs1Val), .rs2Val(rs2Val), .imm(imm),
        .exRs1(exRs1), .exRs2(exRs2), .rd(rd),
        .aluOp(aluOp), .aluSrcImm(aluSrcImm),
        .memRead(memRead), .memWrite(memWrite), .regWrite(regWrite)
    );

    regFile uRegs (
        .clk(clk), .rst_n(rst_n),
        .rs1(rs1), .rs2(rs2), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .wbEn(wbEn), .wbRd(wbRd), .wbData(wbData)
    );

    executeStage uExecute (
        .clk(clk), .rst_n(rst_n), .dcacheStall(dcacheStall),
        .rs1Val(rs1Val), .rs2Val(rs2Val), .imm(imm),
        .rs1(exRs1), .rs2(exRs2), .rd(rd),
        .aluOp(aluOp), .aluSrcImm(aluSrcImm),
        .memRead(memRead), .memWrite(memWrite), .regWrite(regWrite),
        .dcacheRen(dcacheRen), .dcacheWen(dcacheWen),
        .dcacheAddr(dcacheAddr), .dcacheWdata(dcacheWdata), .dcacheRdata(dcacheRdata),
        .exRd(exRd), .exMemRead(exMemRead),
        .wbEn(wbEn), .wbRd(wbRd), .wbData(wbData)
    );

endmodule

//--- hw/executeStage.sv
module executeStage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                dcacheStall,
    input  rvIsaPkg::word_t     rs1Val,
    input  rvIsaPkg::word_t     rs2Val,
    input  rvIsaPkg::word_t     imm,
    input  rvIsaPkg::regIdx_t   rs1,
    input  rvIsaPkg::regIdx_t   rs2,
    input  rvIsaPkg::regIdx_t   rd,
    input  pipeCtrlPkg::aluOp_e aluOp,
    input  logic                aluSrcImm,
    input  logic                memRead,
    input  logic                memWrite,
    input  logic                regWrite,
    output logic                dcacheRen,
    output logic                dcacheWen,
    output rvIsaPkg::wordAddr_t dcacheAddr,
    output rvIsaPkg::word_t     dcacheWdata,
    input  rvIsaPkg::word_t     dcacheRdata,
    output rvIsaPkg::regIdx_t   exRd,
    output logic                exMemRead,
    output logic                wbEn,
    output rvIsaPkg::regIdx_t   wbRd,
    output rvIsaPkg::word_t     wbData
);

    logic                 memRegWrite;
    logic                 memLoad;
    logic                 memStore;
    rvIsaPkg::regIdx_t    memRd;
    rvIsaPkg::word_t      memAlu;
    rvIsaPkg::word_t      memStoreData;
    logic                 wbLoad;
    rvIsaPkg::word_t      wbAlu;
    rvIsaPkg::word_t      wbLoadData;
    pipeCtrlPkg::fwdSel_e fwdA;
    pipeCtrlPkg::fwdSel_e fwdB;
    rvIsaPkg::word_t      opA;
    rvIsaPkg::word_t      opBReg;
    rvIsaPkg::word_t      opB;
    rvIsaPkg::word_t      aluResult;

    // MEM wins over WB, x0 never forwarded
    function automatic pipeCtrlPkg::fwdSel_e pickFwd(
        input rvIsaPkg::regIdx_t src,
        input logic              memWr,
        input rvIsaPkg::regIdx_t memDst,
        input logic              wbWr,
        input rvIsaPkg::regIdx_t wbDst
    );
        if (memWr && memDst != '0 && memDst == src) begin
            return pipeCtrlPkg::fwdMem;
        end else if (wbWr && wbDst != '0 && wbDst == src) begin
            return pipeCtrlPkg::fwdWb;
        end
        return pipeCtrlPkg::fwdNone;
    endfunction

    function automatic rvIsaPkg::word_t fwdMux(
        input pipeCtrlPkg::fwdSel_e sel,
        input rvIsaPkg::word_t      regVal,
        input rvIsaPkg::word_t      memVal,
        input rvIsaPkg::word_t      wbVal
    );
        case (sel)
            pipeCtrlPkg::fwdMem: return memVal;
            pipeCtrlPkg::fwdWb:  return wbVal;
            default:             return regVal;
        endcase
    endfunction

    assign fwdA   = pickFwd(rs1, memRegWrite, memRd, wbEn, wbRd);
    assign fwdB   = pickFwd(rs2, memRegWrite, memRd, wbEn, wbRd);
    assign opA    = fwdMux(fwdA, rs1Val, memAlu, wbData);
    assign opBReg = fwdMux(fwdB, rs2Val, memAlu, wbData); // also the store data
    assign opB    = aluSrcImm ? imm : opBReg;

    always_comb begin
        case (aluOp)
            pipeCtrlPkg::aluSub: aluResult = opA - opB;
            pipeCtrlPkg::aluAnd: aluResult = opA & opB;
            pipeCtrlPkg::aluOr:  aluResult = opA | opB;
            pipeCtrlPkg::aluXor: aluResult = opA ^ opB;
            pipeCtrlPkg::aluSlt: aluResult = {31'b0, $signed(opA) < $signed(opB)};
            pipeCtrlPkg::aluSll: aluResult = opA << opB[4:0];
            pipeCtrlPkg::aluSrl: aluResult = opA >> opB[4:0];
            pipeCtrlPkg::aluSra: aluResult = $signed(opA) >>> opB[4:0];
            default:             aluResult = opA + opB;
        endcase
    end

    // EX/MEM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            memRegWrite <= 1'b0;
            memLoad     <= 1'b0;
            memStore    <= 1'b0;
        end else if (!dcacheStall) begin
            memRegWrite <= regWrite;
            memLoad     <= memRead;
            memStore    <= memWrite;
        end
    end

    always_ff @(posedge clk) begin
        if (!dcacheStall) begin
            memRd        <= rd;
            memAlu       <= aluResult;
            memStoreData <= opBReg;
        end
    end

    // MEM/WB
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wbEn   <= 1'b0;
            wbLoad <= 1'b0;
        end else if (!dcacheStall) begin
            wbEn   <= memRegWrite;
            wbLoad <= memLoad;
        end
    end

    always_ff @(posedge clk) begin
        if (!dcacheStall) begin
            wbRd       <= memRd;
            wbAlu      <= memAlu;
            wbLoadData <= dcacheRdata; // only meaningful after a load
        end
    end

    assign dcacheRen   = memLoad;
    assign dcacheWen   = memStore;
    assign dcacheAddr  = memAlu[31:2];
    assign dcacheWdata = memStoreData;

    assign exRd      = rd;
    assign exMemRead = memRead;
    assign wbData    = wbLoad ? wbLoadData : wbAlu;

    oneDcacheOp: assert property (@(posedge clk) disable iff (!rst_n)
        !(dcacheRen && dcacheWen))
        else $error("dcache read and write together at %h", dcacheAddr);

endmodule

//--- hw/decodeStage.sv
module decodeStage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                dcacheStall,
    input  rvIsaPkg::word_t     pc,
    input  rvIsaPkg::word_t     instr,
    output rvIsaPkg::regIdx_t   rs1,
    output rvIsaPkg::regIdx_t   rs2,
    input  rvIsaPkg::word_t     rs1Data,
    input  rvIsaPkg::word_t     rs2Data,
    input  rvIsaPkg::regIdx_t   exRd,
    input  logic                exMemRead,
    output logic                hold,
    output rvIsaPkg::word_t     rs1Val,
    output rvIsaPkg::word_t     rs2Val,
    output rvIsaPkg::word_t     imm,
    output rvIsaPkg::regIdx_t   exRs1,
    output rvIsaPkg::regIdx_t   exRs2,
    output rvIsaPkg::regIdx_t   rd,
    output pipeCtrlPkg::aluOp_e aluOp,
    output logic                aluSrcImm,
    output logic                memRead,
    output logic                memWrite,
    output logic                regWrite
);

    rvIsaPkg::opcode_t   opcode;
    rvIsaPkg::funct3_t   funct3;
    rvIsaPkg::regIdx_t   instrRd;
    rvIsaPkg::word_t     immI;
    rvIsaPkg::word_t     immS;
    rvIsaPkg::word_t     decImm;
    pipeCtrlPkg::aluOp_e arithOp;
    pipeCtrlPkg::aluOp_e decAluOp;
    logic                altOp;
    logic                decSrcImm;
    logic                decMemRead;
    logic                decMemWrite;
    logic                decRegWrite;
    logic                usesRs1;
    logic                usesRs2;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign instrRd = instr[11:7];
    assign rs1     = instr[19:15];
    assign rs2     = instr[24:20];
    assign altOp   = instr[30];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    always_comb begin
        case (funct3)
            rvIsaPkg::f3AddSub: arithOp = (opcode == rvIsaPkg::opOp && altOp) ?
                                          pipeCtrlPkg::aluSub : pipeCtrlPkg::aluAdd;
            rvIsaPkg::f3Sll:    arithOp = pipeCtrlPkg::aluSll;
            rvIsaPkg::f3Slt:    arithOp = pipeCtrlPkg::aluSlt;
            rvIsaPkg::f3Xor:    arithOp = pipeCtrlPkg::aluXor;
            rvIsaPkg::f3SrlSra: arithOp = altOp ? pipeCtrlPkg::aluSra : pipeCtrlPkg::aluSrl;
            rvIsaPkg::f3Or:     arithOp = pipeCtrlPkg::aluOr;
            rvIsaPkg::f3And:    arithOp = pipeCtrlPkg::aluAnd;
            default:            arithOp = pipeCtrlPkg::aluAdd; // sltu not supported
        endcase
    end

    always_comb begin
        decAluOp    = pipeCtrlPkg::aluAdd;
        decSrcImm   = 1'b0;
        decMemRead  = 1'b0;
        decMemWrite = 1'b0;
        decRegWrite = 1'b0;
        decImm      = immI;
        usesRs1     = 1'b1;
        usesRs2     = 1'b0;
        case (opcode)
            rvIsaPkg::opOp: begin
                decAluOp    = arithOp;
                decRegWrite = 1'b1;
                usesRs2     = 1'b1;
            end
            rvIsaPkg::opOpImm: begin
                decAluOp    = arithOp;
                decSrcImm   = 1'b1;
                decRegWrite = 1'b1;
            end
            rvIsaPkg::opLoad: begin
                decSrcImm   = 1'b1;
                decMemRead  = 1'b1;
                decRegWrite = 1'b1;
            end
            rvIsaPkg::opStore: begin
                decSrcImm   = 1'b1;
                decMemWrite = 1'b1;
                decImm      = immS;
                usesRs2     = 1'b1;
            end
            default: usesRs1 = 1'b0; // nop or unsupported
        endcase
    end

    // load in EX feeding this instruction
    assign hold = exMemRead && (exRd != '0) &&
                  ((usesRs1 && exRd == rs1) || (usesRs2 && exRd == rs2));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            aluOp     <= pipeCtrlPkg::aluAdd;
            aluSrcImm <= 1'b0;
            memRead   <= 1'b0;
            memWrite  <= 1'b0;
            regWrite  <= 1'b0;
        end else if (!dcacheStall) begin
            aluOp     <= decAluOp;
            aluSrcImm <= decSrcImm;
            memRead   <= decMemRead & ~hold; // bubble on load-use
            memWrite  <= decMemWrite & ~hold;
            regWrite  <= decRegWrite & ~hold;
        end
    end

    always_ff @(posedge clk) begin
        if (!dcacheStall) begin
            rs1Val <= rs1Data;
            rs2Val <= rs2Data;
            imm    <= decImm;
            exRs1  <= rs1;
            exRs2  <= rs2;
            rd     <= instrRd;
        end
    end

    holdOneCycle: assert property (@(posedge clk) disable iff (!rst_n)
        hold && !dcacheStall |=> !hold)
        else $error("load-use hold lasted two cycles");

    // fetch must keep IF/ID while decode waits
    holdKeepsIfId: assert property (@(posedge clk) disable iff (!rst_n)
        hold |=> $stable(pc) && $stable(instr))
        else $error("IF/ID moved under hold, pc %h", pc);

endmodule

//--- hw/regFile.sv
module regFile (
    input  logic              clk,
    input  logic              rst_n,
    input  rvIsaPkg::regIdx_t rs1,
    input  rvIsaPkg::regIdx_t rs2,
    output rvIsaPkg::word_t   rs1Data,
    output rvIsaPkg::word_t   rs2Data,
    input  logic              wbEn,
    input  rvIsaPkg::regIdx_t wbRd,
    input  rvIsaPkg::word_t   wbData
);

    rvIsaPkg::word_t regs [32];
    logic            wrLive;

    assign wrLive = wbEn && (wbRd != '0); // x0 writes dropped here

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wbRd] <= wbData;
        end
    end

    // decode sees this cycle's writeback
    assign rs1Data = (wrLive && wbRd == rs1) ? wbData : regs[rs1];
    assign rs2Data = (wrLive && wbRd == rs2) ? wbData : regs[rs2];

    x0Zero: assert property (@(posedge clk) disable iff (!rst_n)
        regs[0] == '0)
        else $error("x0 holds %h", regs[0]);

endmodule

//--- hw/fetchStage.sv
module fetchStage #(
    parameter rvIsaPkg::word_t resetPc = pipeCtrlPkg::defaultResetPc
) (
    input  logic                clk,
    input  logic                rst_n,
    output rvIsaPkg::wordAddr_t icacheAddr,
    input  rvIsaPkg::word_t     icacheRdata,
    input  logic                icacheStall,
    input  logic                dcacheStall,
    input  logic                hold,
    output rvIsaPkg::word_t     pc,
    output rvIsaPkg::word_t     instr
);

    rvIsaPkg::word_t fetchPc;
    logic            freezeIfId;
    logic            advance;

    assign freezeIfId = dcacheStall | hold; // IF/ID keeps its word
    assign advance    = ~freezeIfId & ~icacheStall;
    assign icacheAddr = fetchPc[31:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetchPc <= resetPc;
        end else if (advance) begin
            fetchPc <= fetchPc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instr <= rvIsaPkg::nopWord;
        end else if (!freezeIfId) begin
            instr <= icacheStall ? rvIsaPkg::nopWord : icacheRdata; // bubble while fetch pending
        end
    end

    always_ff @(posedge clk) begin
        if (!freezeIfId) begin
            pc <= fetchPc;
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (!rst_n)
        fetchPc[1:0] == 2'b00)
        else $error("fetch pc %h is not word aligned", fetchPc);

endmodule

//--- hw/pipeCtrlPkg.sv
package pipeCtrlPkg;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluSrl,
        aluSra
    } aluOp_e;

    // operand source in EX
    typedef enum logic [1:0] {
        fwdNone,
        fwdMem,
        fwdWb
    } fwdSel_e;

    // first fetch address after reset
    localparam rvIsaPkg::word_t defaultResetPc = 32'h0000_0000;

endpackage

//--- hw/rvIsaPkg.sv
package rvIsaPkg;

    typedef logic [31:0] word_t;     // data or instruction word
    typedef logic [4:0]  regIdx_t;
    typedef logic [29:0] wordAddr_t; // cache side address, byte offset dropped
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // major opcodes
    localparam opcode_t opOp    = 7'b0110011;
    localparam opcode_t opOpImm = 7'b0010011;
    localparam opcode_t opLoad  = 7'b0000011;
    localparam opcode_t opStore = 7'b0100011;

    localparam funct3_t f3AddSub = 3'b000;
    localparam funct3_t f3Sll    = 3'b001;
    localparam funct3_t f3Slt    = 3'b010;
    localparam funct3_t f3Xor    = 3'b100;
    localparam funct3_t f3SrlSra = 3'b101;
    localparam funct3_t f3Or     = 3'b110;
    localparam funct3_t f3And    = 3'b111;
    localparam funct3_t f3Word   = 3'b010; // lw and sw

    localparam funct7_t f7Base = 7'b0000000;
    localparam funct7_t f7Alt  = 7'b0100000; // sub, sra, srai

    // opcode 0 matches nothing, so this decodes to no controls
    localparam word_t nopWord = 32'h0000_0000;

endpackage
